// File: rtl/rob_entry_pkg.sv
/*
 * ROB entry record definitions
 * Layout of the reorder-buffer entry record. The same packed word is
 * the create payload from rename and the read-back word of the entry.
 * The static create-time fields sit in the upper bits, then the
 * load/store flags, the fold count, and the complete and valid bits.
 */
package rob_entry_pkg;

  localparam int CNT_W       = 2;
  localparam int PC_OFFSET_W = 3;
  localparam int INST_NUM_W  = 2;

  // fields written only at create time
  typedef struct packed {
    logic [PC_OFFSET_W-1:0] pc_offset;
    logic                   split;
    logic                   intmask;
    logic                   bju;
    logic                   pcfifo;
    logic                   ras;
    logic                   store;
    logic                   bkpta_inst;
    logic                   bkptb_inst;
    logic [INST_NUM_W-1:0]  inst_num;
    logic                   fp_dirty;
    logic                   load;
  } rob_info_t;

  // load/store debug and speculation flags
  typedef struct packed {
    logic bkpta_data;
    logic bkptb_data;
    logic no_spec_hit;
    logic no_spec_miss;
    logic no_spec_mispred;
  } rob_lsu_t;

  // full record, vld at bit 0
  typedef struct packed {
    rob_info_t        info;
    rob_lsu_t         lsu;
    logic [CNT_W-1:0] cmplt_cnt;
    logic             cmplt;
    logic             vld;
  } rob_entry_t;

endpackage

// File: rtl/rob_cmplt_pkg.sv
/*
 * Completion pipe definitions
 * Pipe vector seen by the entry, which pipes can retire a folded part,
 * and the write-back flags sent by the two load/store pipes.
 */
package rob_cmplt_pkg;

  localparam int CMPLT_PIPES = 8;

  typedef logic [CMPLT_PIPES-1:0] cmplt_vec_t;

  // pipes 0, 1, 5 and 6 may finish one part of a fused instruction
  localparam cmplt_vec_t FOLD_PIPES = 8'b0110_0011;

  // load/store write-back pipes
  localparam int LSU_PIPE_A = 3;
  localparam int LSU_PIPE_B = 4;

  // same bit order as the entry's load/store flags
  typedef struct packed {
    logic bkpta_data;
    logic bkptb_data;
    logic no_spec_hit;
    logic no_spec_miss;
    logic no_spec_mispred;
  } lsu_wb_t;

endpackage

// File: rtl/rob_create_select.sv
/*
 * Create port select
 * AND-OR mux that returns the record of the port picked by a one-hot
 * select. A select that is not one-hot gives an undefined record.
 */
module rob_create_select
  import rob_entry_pkg::*;
#(
  parameter int CREATE_PORTS = 4
) (
  input  rob_entry_t              create_data [CREATE_PORTS],
  input  logic [CREATE_PORTS-1:0] create_sel,
  output rob_entry_t              create_rec
);

  localparam int REC_W = $bits(rob_entry_t);

  logic [REC_W-1:0] rec_or;

  always_comb begin
    rec_or = '0;
    // each port masked by its own select bit
    for (int i = 0; i < CREATE_PORTS; i++) begin
      rec_or = rec_or | ({REC_W{create_sel[i]}} & create_data[i]);
    end
  end

  assign create_rec = rob_entry_t'(rec_or);

endmodule

// File: rtl/rob_entry_state.sv
/*
 * Entry valid/complete state
 * FSM over the pair {vld, cmplt}. Flush wins over create, create over
 * pop for the valid bit; completion wins over create for cmplt.
 */
module rob_entry_state
  import rob_entry_pkg::*;
  import rob_cmplt_pkg::*;
(
  input  logic       entry_clk,
  input  logic       cpurst_b,
  input  rob_entry_t create_rec,
  input  logic       create_en,
  input  logic       pop_en,
  input  logic       flush,
  input  cmplt_vec_t cmplt_vld,
  input  logic       cmplt_set,
  output logic       vld,
  output logic       cmplt
);

  // encoding is {vld, cmplt}
  typedef enum logic [1:0] {
    EMPTY   = 2'b00,
    STALE   = 2'b01,
    PENDING = 2'b10,
    DONE    = 2'b11
  } entry_state_e;

  entry_state_e state_q;
  entry_state_e state_d;
  logic         vld_nxt;
  logic         cmplt_nxt;

  assign vld   = (state_q == PENDING) || (state_q == DONE);
  assign cmplt = (state_q == DONE) || (state_q == STALE);

  always_comb begin
    // valid bit
    if (flush) begin
      vld_nxt = 1'b0;
    end else if (create_en) begin
      vld_nxt = create_rec.vld;
    end else if (pop_en) begin
      vld_nxt = 1'b0;
    end else begin
      vld_nxt = vld;
    end
    // complete bit, untouched by flush and pop
    if (|cmplt_vld) begin
      cmplt_nxt = cmplt_set;
    end else if (create_en) begin
      cmplt_nxt = create_rec.cmplt;
    end else begin
      cmplt_nxt = cmplt;
    end
    state_d = entry_state_e'({vld_nxt, cmplt_nxt});
  end

  always_ff @(posedge entry_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      state_q <= EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: rtl/rob_fold_counter.sv
/*
 * Fold completion counter
 * Counts the parts of a fused instruction still outstanding and decides
 * whether this cycle's completions finish the instruction.
 */
module rob_fold_counter
  import rob_entry_pkg::*;
  import rob_cmplt_pkg::*;
(
  input  logic             entry_clk,
  input  logic             cpurst_b,
  input  rob_entry_t       create_rec,
  input  logic             create_en,
  input  cmplt_vec_t       cmplt_vld,
  output logic [CNT_W-1:0] cmplt_cnt,
  output logic             cmplt_set
);

  localparam int K_W = $clog2(CMPLT_PIPES + 1);

  cmplt_vec_t       fold_hit;
  logic [K_W-1:0]   fold_k;
  logic [CNT_W-1:0] cnt_base;
  logic [CNT_W-1:0] cnt_nxt;
  logic             any_cmplt;
  logic             plain_cmplt;

  // ========================================
  // completion decode
  // ========================================
  assign fold_hit    = cmplt_vld & FOLD_PIPES;
  assign any_cmplt   = |cmplt_vld;
  // pipes 2, 3, 4 and 7 never carry folded parts
  assign plain_cmplt = |(cmplt_vld & ~FOLD_PIPES);

  always_comb begin
    fold_k = '0;
    for (int i = 0; i < CMPLT_PIPES; i++) begin
      if (fold_hit[i]) begin
        fold_k = fold_k + K_W'(1);
      end
    end
  end

  // a same-cycle create supplies the base
  assign cnt_base = create_en ? create_rec.cmplt_cnt : cmplt_cnt;

  always_comb begin
    if ((fold_k == K_W'(1)) || (fold_k == K_W'(2))) begin
      cnt_nxt = cnt_base - CNT_W'(fold_k);
    end else begin
      cnt_nxt = '0;
    end
  end

  assign cmplt_set = ((fold_k == K_W'(1)) && (cnt_base == CNT_W'(1)))
                  || ((fold_k == K_W'(2)) && (cnt_base == CNT_W'(2)))
                  || (fold_k == K_W'(3))
                  || plain_cmplt;

  // ========================================
  // count register
  // ========================================
  always_ff @(posedge entry_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      cmplt_cnt <= '0;
    end else if (any_cmplt) begin
      cmplt_cnt <= cnt_nxt;
    end else if (create_en) begin
      cmplt_cnt <= create_rec.cmplt_cnt;
    end
  end

endmodule

// File: rtl/rob_lsu_flags.sv
/*
 * Load/store write-back flags
 * Breakpoint and no-speculation flags. A write-back on pipe 3 or 4
 * takes the OR of the completing pipes, else create_dp_en loads them.
 */
module rob_lsu_flags
  import rob_entry_pkg::*;
  import rob_cmplt_pkg::*;
(
  input  logic       entry_clk,
  input  logic       cpurst_b,
  input  rob_entry_t create_rec,
  input  logic       create_dp_en,
  input  cmplt_vec_t cmplt_vld,
  input  lsu_wb_t    lsu_wb_a,
  input  lsu_wb_t    lsu_wb_b,
  output rob_lsu_t   lsu
);

  localparam int WB_W = $bits(lsu_wb_t);

  logic    wb_a_vld;
  logic    wb_b_vld;
  lsu_wb_t wb_merged;

  assign wb_a_vld = cmplt_vld[LSU_PIPE_A];
  assign wb_b_vld = cmplt_vld[LSU_PIPE_B];

  // flags of an idle pipe are masked off
  assign wb_merged = lsu_wb_t'(({WB_W{wb_a_vld}} & lsu_wb_a)
                             | ({WB_W{wb_b_vld}} & lsu_wb_b));

  always_ff @(posedge entry_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      lsu <= '0;
    end else if (wb_a_vld || wb_b_vld) begin
      lsu <= rob_lsu_t'(wb_merged);
    end else if (create_dp_en) begin
      lsu <= create_rec.lsu;
    end
  end

endmodule

// File: rtl/rob_create_info.sv
/*
 * Create-time fields
 * Static instruction fields, written on create_dp_en only and
 * held until the next create.
 */
module rob_create_info
  import rob_entry_pkg::*;
(
  input  logic       entry_clk,
  input  logic       cpurst_b,
  input  rob_entry_t create_rec,
  input  logic       create_dp_en,
  output rob_info_t  info
);

  // pc offset, branch/ras info, inst count and such
  always_ff @(posedge entry_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      info <= '0;
    end else if (create_dp_en) begin
      info <= create_rec.info;
    end
  end

endmodule

// File: rtl/rob_entry_top.sv
/*
 * ROB entry
 * One reorder-buffer entry of the retire unit. Picks the create record
 * from the rename ports, then keeps valid/complete state, the fold
 * counter, the load/store flags and the static fields. All of it is
 * read back as one record.
 */
module rob_entry_top
  import rob_entry_pkg::*;
  import rob_cmplt_pkg::*;
#(
  parameter int CREATE_PORTS = 4
) (
  input  logic                    entry_clk,
  input  logic                    cpurst_b,
  input  rob_entry_t              create_data [CREATE_PORTS],
  input  logic [CREATE_PORTS-1:0] create_sel,
  input  logic                    create_en,
  input  logic                    create_dp_en,
  input  logic                    pop_en,
  input  logic                    flush,
  input  cmplt_vec_t              cmplt_vld,
  input  lsu_wb_t                 lsu_wb_a,
  input  lsu_wb_t                 lsu_wb_b,
  output rob_entry_t              read_data
);

  rob_entry_t       create_rec;
  logic             cmplt_set;
  logic             vld;
  logic             cmplt;
  logic [CNT_W-1:0] cmplt_cnt;
  rob_lsu_t         lsu;
  rob_info_t        info;

  // ========================================
  // create port select
  // ========================================
  rob_create_select #(
    .CREATE_PORTS (CREATE_PORTS)
  ) u_create_select (
    .create_data (create_data),
    .create_sel  (create_sel),
    .create_rec  (create_rec)
  );

  // ========================================
  // entry state and fold count
  // ========================================
  rob_entry_state u_entry_state (
    .entry_clk (entry_clk),
    .cpurst_b  (cpurst_b),
    .create_rec(create_rec),
    .create_en (create_en),
    .pop_en    (pop_en),
    .flush     (flush),
    .cmplt_vld (cmplt_vld),
    .cmplt_set (cmplt_set),
    .vld       (vld),
    .cmplt     (cmplt)
  );

  rob_fold_counter u_fold_counter (
    .entry_clk (entry_clk),
    .cpurst_b  (cpurst_b),
    .create_rec(create_rec),
    .create_en (create_en),
    .cmplt_vld (cmplt_vld),
    .cmplt_cnt (cmplt_cnt),
    .cmplt_set (cmplt_set)
  );

  // ========================================
  // payload fields
  // ========================================
  rob_lsu_flags u_lsu_flags (
    .entry_clk   (entry_clk),
    .cpurst_b    (cpurst_b),
    .create_rec  (create_rec),
    .create_dp_en(create_dp_en),
    .cmplt_vld   (cmplt_vld),
    .lsu_wb_a    (lsu_wb_a),
    .lsu_wb_b    (lsu_wb_b),
    .lsu         (lsu)
  );

  rob_create_info u_create_info (
    .entry_clk   (entry_clk),
    .cpurst_b    (cpurst_b),
    .create_rec  (create_rec),
    .create_dp_en(create_dp_en),
    .info        (info)
  );

  // read-back word, straight from the registers
  assign read_data = '{
    info:      info,
    lsu:       lsu,
    cmplt_cnt: cmplt_cnt,
    cmplt:     cmplt,
    vld:       vld
  };

endmodule

// File: tests/rob_entry_properties.sv
/*
 * ROB entry properties
 * Concurrent checks bound into the entry top level: one-hot create
 * select, valid cleared after flush, and fold count stability.
 */
module rob_entry_properties
  import rob_entry_pkg::*;
  import rob_cmplt_pkg::*;
#(
  parameter int CREATE_PORTS = 4
) (
  input logic                    entry_clk,
  input logic                    cpurst_b,
  input logic [CREATE_PORTS-1:0] create_sel,
  input logic                    create_en,
  input logic                    create_dp_en,
  input logic                    flush,
  input cmplt_vec_t              cmplt_vld,
  input rob_entry_t              read_data
);

  // number of failed assertions so far
  int unsigned fail_count = 0;

  // ========================================
  // create port select
  // ========================================
  a_create_sel_onehot: assert property (
    @(posedge entry_clk) disable iff (!cpurst_b)
      (create_en || create_dp_en) |-> $onehot(create_sel)
  ) else begin
    fail_count++;
    $error("create_sel is not one-hot while a create strobe is high");
  end

  // ========================================
  // entry state
  // ========================================
  a_flush_clears_vld: assert property (
    @(posedge entry_clk) disable iff (!cpurst_b)
      flush |=> !read_data.vld
  ) else begin
    fail_count++;
    $error("vld still set in the cycle after a flush");
  end

  // count moves only on create or completion
  a_cnt_stable: assert property (
    @(posedge entry_clk) disable iff (!cpurst_b)
      (!create_en && !(|cmplt_vld)) |=> $stable(read_data.cmplt_cnt)
  ) else begin
    fail_count++;
    $error("cmplt_cnt changed without create_en or a completion");
  end

endmodule

// File: tests/rob_entry_tb.sv
/*
 * ROB entry testbench
 * Reads per-cycle input vectors and expected read words from the
 * stimulus file, drives them on the falling edge and compares each
 * field of the read word after the following rising edge.
 */
module rob_entry_tb
  import rob_entry_pkg::*;
  import rob_cmplt_pkg::*;
();

  localparam int    CREATE_PORTS = 4;
  localparam int    CLK_PERIOD   = 20;
  localparam int    RESET_CYCLES = 5;
  localparam int    MAX_VEC      = 64;
  localparam int    VEC_W        = 80;
  localparam string STIM_FILE    = "tests/rob_entry_stimulus.txt";
  // unused slots keep this value, so the vector count is found from it
  localparam logic [VEC_W-1:0] END_MARK = '1;

  logic                    entry_clk;
  logic                    cpurst_b;
  rob_entry_t              create_data [CREATE_PORTS];
  logic [CREATE_PORTS-1:0] create_sel;
  logic                    create_en;
  logic                    create_dp_en;
  logic                    pop_en;
  logic                    flush;
  cmplt_vec_t              cmplt_vld;
  lsu_wb_t                 lsu_wb_a;
  lsu_wb_t                 lsu_wb_b;
  rob_entry_t              read_data;

  logic [VEC_W-1:0] vec_mem [MAX_VEC];
  int               num_vec;
  logic             stim_loaded;

  rob_entry_top #(
    .CREATE_PORTS (CREATE_PORTS)
  ) u_rob_entry_top (
    .entry_clk   (entry_clk),
    .cpurst_b    (cpurst_b),
    .create_data (create_data),
    .create_sel  (create_sel),
    .create_en   (create_en),
    .create_dp_en(create_dp_en),
    .pop_en      (pop_en),
    .flush       (flush),
    .cmplt_vld   (cmplt_vld),
    .lsu_wb_a    (lsu_wb_a),
    .lsu_wb_b    (lsu_wb_b),
    .read_data   (read_data)
  );

  bind rob_entry_top rob_entry_properties #(
    .CREATE_PORTS (CREATE_PORTS)
  ) u_properties (
    .entry_clk   (entry_clk),
    .cpurst_b    (cpurst_b),
    .create_sel  (create_sel),
    .create_en   (create_en),
    .create_dp_en(create_dp_en),
    .flush       (flush),
    .cmplt_vld   (cmplt_vld),
    .read_data   (read_data)
  );

  initial entry_clk = 1'b0;
  always #(CLK_PERIOD / 2) entry_clk = ~entry_clk;

  // ========================================
  // helpers
  // ========================================
  task automatic check_value(input string what, input logic [23:0] actual,
                             input logic [23:0] expected);
    if (actual !== expected) begin
      $display("ERROR at time %0t: %s mismatch, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("Test FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // stop as soon as a bound property has failed
  task automatic check_assertions();
    if (u_rob_entry_top.u_properties.fail_count != 0) begin
      $display("Test FAILED");
      $fatal(1, "a bound assertion failed at or before time %0t", $time);
    end
  endtask

  // line layout: sel, {create_en, create_dp_en, pop_en, flush}, cmplt_vld,
  // lsu_wb_a, lsu_wb_b, record, expected read word
  task automatic drive_vector(input logic [VEC_W-1:0] v);
    logic [23:0] rec;
    rec          = v[47:24];
    create_sel   = v[79:76];
    create_en    = v[75];
    create_dp_en = v[74];
    pop_en       = v[73];
    flush        = v[72];
    cmplt_vld    = v[71:64];
    lsu_wb_a     = lsu_wb_t'(v[60:56]);
    lsu_wb_b     = lsu_wb_t'(v[52:48]);
    // unselected ports carry the inverted record
    for (int p = 0; p < CREATE_PORTS; p++) begin
      if (v[76 + p]) begin
        create_data[p] = rob_entry_t'(rec);
      end else begin
        create_data[p] = rob_entry_t'(~rec);
      end
    end
  endtask

  task automatic compare_read_word(input int idx, input rob_entry_t exp_word);
    check_value($sformatf("vector %0d info", idx), 24'(read_data.info), 24'(exp_word.info));
    check_value($sformatf("vector %0d lsu", idx), 24'(read_data.lsu), 24'(exp_word.lsu));
    check_value($sformatf("vector %0d cmplt_cnt", idx), 24'(read_data.cmplt_cnt),
                24'(exp_word.cmplt_cnt));
    check_value($sformatf("vector %0d cmplt", idx), 24'(read_data.cmplt),
                24'(exp_word.cmplt));
    check_value($sformatf("vector %0d vld", idx), 24'(read_data.vld), 24'(exp_word.vld));
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    cpurst_b     = 1'b0;
    create_sel   = '0;
    create_en    = 1'b0;
    create_dp_en = 1'b0;
    pop_en       = 1'b0;
    flush        = 1'b0;
    cmplt_vld    = '0;
    lsu_wb_a     = '0;
    lsu_wb_b     = '0;
    stim_loaded  = 1'b0;
    num_vec      = 0;
    for (int p = 0; p < CREATE_PORTS; p++) begin
      create_data[p] = '0;
    end
    for (int i = 0; i < MAX_VEC; i++) begin
      vec_mem[i] = END_MARK;
    end
    $readmemh(STIM_FILE, vec_mem);
    while (num_vec < MAX_VEC && vec_mem[num_vec] !== END_MARK) begin
      num_vec++;
    end
    if (num_vec == 0) begin
      $display("Test FAILED");
      $fatal(1, "no stimulus vectors could be read from %s", STIM_FILE);
    end
    stim_loaded = 1'b1;

    repeat (RESET_CYCLES) @(posedge entry_clk);
    @(negedge entry_clk);
    cpurst_b = 1'b1;
    check_value("read_data after reset", 24'(read_data), 24'h0);

    for (int i = 0; i < num_vec; i++) begin
      drive_vector(vec_mem[i]);
      @(negedge entry_clk);
      compare_read_word(i, rob_entry_t'(vec_mem[i][23:0]));
      check_assertions();
    end

    $display("Test OK");
    $finish;
  end

  // ========================================
  // watchdog
  // ========================================
  initial begin
    wait (stim_loaded);
    #((num_vec + 10) * CLK_PERIOD * 2);
    $display("Test FAILED");
    $fatal(1, "timeout, the stimulus did not finish in the allowed time");
  end

endmodule

// File: rob_entry_top.f
rtl/rob_entry_pkg.sv
rtl/rob_cmplt_pkg.sv
rtl/rob_create_select.sv
rtl/rob_entry_state.sv
rtl/rob_fold_counter.sv
rtl/rob_lsu_flags.sv
rtl/rob_create_info.sv
rtl/rob_entry_top.sv
tests/rob_entry_properties.sv
tests/rob_entry_tb.sv

// File: Makefile
# Verilator flow for the ROB entry: lint, simulate, clean

VERILATOR ?= verilator
TOP       ?= rob_entry_tb
FILE_LIST ?= rob_entry_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test OK

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILE_LIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run passes only if the log holds the pass line
sim: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/rob_entry_stimulus.txt
// columns: sel _ {create_en,create_dp_en,pop_en,flush} _ cmplt_vld _ lsu_wb_a _ lsu_wb_b
//          _ record for the selected port _ expected read word after the next rising edge
// idle after reset
0_0_00_00_00_000000_000000
// create through each port, other ports get the inverted record
1_c_00_00_00_5a3b71_5a3b71
2_c_00_00_00_c3e48d_c3e48d
4_c_00_00_00_9f0226_9f0226
8_c_00_00_00_36d5bb_36d5bb
// valid priorities: flush over create, create over pop, pop alone
1_9_00_00_00_000005_36d5b4
2_a_00_00_00_00000b_36d5bb
0_2_00_00_00_000000_36d5ba
4_8_00_00_00_000009_36d5b9
// fold counting from 2, idle lsu pipes carry flags that must be ignored
0_0_01_1f_1f_000000_36d5b5
0_0_20_00_00_000000_36d5b3
8_8_00_00_00_000009_36d5b9
0_0_42_00_00_000000_36d5b3
// pipes 2 and 7 complete the whole instruction
1_8_00_00_00_00000d_36d5bd
0_0_04_00_00_000000_36d5b3
2_8_00_00_00_00000d_36d5bd
0_0_80_00_00_000000_36d5b3
// create and completion together use the created count
4_8_01_00_00_000005_36d5b3
8_8_02_00_00_00000d_36d5b9
// three fold parts at once
0_0_23_00_00_000000_36d5b3
// load/store flags: pipe 3 alone, then pipes 3 and 4 merged
0_0_08_04_13_000000_36d443
0_0_18_01_0a_000000_36d4b3
// create_dp_en alone, state bits hold
8_4_00_1f_1f_e1f2cc_e1f2c3
// pipe 4 write-back beats create_dp_en for the flags
1_4_10_19_06_7b4e5f_7b4e63
2_8_00_00_00_00000d_7b4e6d
4_4_00_00_00_0c1a92_0c1a9d
// flush with pop, then idle
0_3_00_00_00_000000_0c1a9c
0_0_00_00_00_000000_0c1a9c
